/* flist.f */
+incdir+hw
hw/tm1638_pkg.sv
hw/sio_byte_if.sv
hw/sio_arbiter.sv
hw/tm1638_sio_engine.sv
hw/tm1638_display_writer.sv
hw/tm1638_key_reader.sv
hw/tm1638_board_controller.sv
sim/tm1638_panel_checker.sv
sim/tb_tm1638.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the TM1638 controller testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_tm1638 -f flist.f -o tb_tm1638_sim

./obj_dir/tb_tm1638_sim | tee sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi

echo "Simulation finished without failures"

/* sim/tb_tm1638.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tb_tm1638;

    localparam int N_REFRESH   = 10;
    localparam int BYTE_CYCLES = 17 * `TM_HALF_PERIOD;  // Eight bit periods and the lead-in
    // 19 display bytes and 15 key bytes per refresh, six frames with tails
    localparam int PAIR_CYCLES = 34 * BYTE_CYCLES + 6 * 4 * `TM_HALF_PERIOD;
    localparam int HOLD_CYCLES = 3 * PAIR_CYCLES;
    localparam int TIMEOUT     = 2 * N_REFRESH * PAIR_CYCLES;
    localparam int DIG_W       = $clog2(`TM_DIGITS);
    localparam int KEY_W       = $clog2(`TM_KEYS);

    logic                    clk;
    logic                    rst_n;
    logic [7:0]              hgfedcba;
    logic [`TM_DIGITS - 1:0] digit;
    logic [`TM_DIGITS - 1:0] ledr;
    logic [`TM_KEYS - 1:0]   keys;
    logic                    sio_clk;
    logic                    sio_stb;
    logic                    sio_data_out;
    logic                    sio_data_oe;
    logic                    sio_data_in;

    tm1638_pkg::seg_mem_t    seg_ref;     // Pattern for each digit position
    logic [`TM_KEYS - 1:0]   key_pat;     // Keys held down on the panel
    logic [`TM_KEYS - 1:0]   frame_keys;  // Keys sent in the current key frame
    logic [31:0]             rng;
    int                      hold_cnt;
    int                      scan_pos;
    int                      cycles;
    int                      tb_errors;
    int                      error_count;
    int                      refreshes;
    int                      compared;
    int                      key_frames;

    // Panel model
    logic                    panel_clk_q;
    logic                    panel_reading;
    logic [7:0]              panel_cmd;
    int                      panel_bits;
    int                      panel_reads;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Key 2i in bit 0 and key 2i+1 in bit 4 of read byte i
    function automatic logic key_bit(input logic [`TM_KEYS - 1:0] k, input int n);
        int i;
        int b;
        i = n / 8;
        b = n % 8;
        if (n >= 4 * 8)
            return 1'b0;
        if (b == 0)
            return k[KEY_W'(2 * i)];
        if (b == 4)
            return k[KEY_W'(2 * i + 1)];
        return 1'b0;
    endfunction

    tm1638_board_controller i_tm1638_board_controller
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .hgfedcba     ( hgfedcba     ),
        .digit        ( digit        ),
        .ledr         ( ledr         ),
        .keys         ( keys         ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

    tm1638_panel_checker i_panel_checker
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  ),
        .keys         ( keys         ),
        .seg_ref      ( seg_ref      ),
        .ledr         ( ledr         ),
        .panel_keys   ( frame_keys   ),
        .error_count  ( error_count  ),
        .refreshes    ( refreshes    ),
        .compared     ( compared     ),
        .key_frames   ( key_frames   )
    );

    always #2 clk = ~clk;

    // ----------------------------------------
    // Lab side stimulus
    // ----------------------------------------

    always @(posedge clk)
    begin
        if (hold_cnt == 0)  // New random values, held for several refreshes
        begin
            for (int k = 0; k < `TM_DIGITS; k++)
            begin
                rng = xorshift32(rng);
                seg_ref[DIG_W'(k)] <= rng[7:0];
            end
            rng = xorshift32(rng);
            ledr    <= rng[15:8];
            key_pat <= rng[23:16];
        end
        hold_cnt <= (hold_cnt == HOLD_CYCLES - 1) ? 0 : hold_cnt + 1;
        digit    <= `TM_DIGITS'(1) << scan_pos;  // One position per cycle
        hgfedcba <= seg_ref[DIG_W'(scan_pos)];
        scan_pos <= (scan_pos == `TM_DIGITS - 1) ? 0 : scan_pos + 1;
    end

    // ----------------------------------------
    // Panel answering key reads
    // ----------------------------------------

    always @(posedge clk)
    begin
        panel_clk_q <= sio_clk;
        if (sio_stb)
        begin
            panel_bits    = 0;
            panel_reading = 1'b0;
            sio_data_in  <= 1'b0;
        end
        else if (!panel_clk_q && sio_clk)
        begin
            if (panel_reading)
                panel_reads++;
            else if (panel_bits < 8)
            begin
                panel_cmd = {sio_data_out, panel_cmd[7:1]};
                panel_bits++;
                if (panel_bits == 8 && panel_cmd == `TM_CMD_DATA_READ)
                begin
                    panel_reading = 1'b1;
                    panel_reads   = 0;
                    frame_keys   <= key_pat;
                end
            end
        end
        else if (panel_clk_q && !sio_clk && panel_reading)
            sio_data_in <= key_bit(frame_keys, panel_reads);  // Next bit on the fall
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= TIMEOUT)
        begin
            $display("Timeout after %0d cycles, the display refreshes did not complete", cycles);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        clk           = 1'b0;
        rst_n         = 1'b0;
        hgfedcba      = 8'd0;
        digit         = '0;
        ledr          = '0;
        sio_data_in   = 1'b0;
        seg_ref       = '0;
        key_pat       = '0;
        frame_keys    = '0;
        rng           = 32'h1c95e8cb;
        hold_cnt      = 0;
        scan_pos      = 0;
        cycles        = 0;
        tb_errors     = 0;
        panel_clk_q   = 1'b1;
        panel_reading = 1'b0;
        panel_cmd     = 8'd0;
        panel_bits    = 0;
        panel_reads   = 0;

        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        while (refreshes < N_REFRESH)
            @(negedge clk);

        if (compared < N_REFRESH / 2)
        begin
            $display("Only %0d display refreshes had stable inputs to compare", compared);
            tb_errors++;
        end
        if (key_frames < N_REFRESH)
        begin
            $display("Key frames fell behind, %0d for %0d refreshes", key_frames, refreshes);
            tb_errors++;
        end

        $display("Checker errors %0d, testbench errors %0d, refreshes %0d, compared %0d, keys %0d",
                 error_count, tb_errors, refreshes, compared, key_frames);
        if (error_count == 0 && tb_errors == 0)
            $display("ALL TESTS PASSED");
        else
            $display("SOME TESTS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* sim/tm1638_panel_checker.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tm1638_panel_checker
(
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         sio_clk,
    input  wire                         sio_stb,
    input  wire                         sio_data_out,
    input  wire                         sio_data_oe,
    input  wire                         sio_data_in,
    input  wire  [`TM_KEYS - 1:0]       keys,
    input  wire  [8 * `TM_DIGITS - 1:0] seg_ref,     // Pattern presented per digit
    input  wire  [`TM_DIGITS - 1:0]     ledr,
    input  wire  [`TM_KEYS - 1:0]       panel_keys,  // Keys the panel sent in the last key frame
    output int                          error_count,
    output int                          refreshes,
    output int                          compared,
    output int                          key_frames
);

    localparam int PAYLOAD    = 2 * `TM_DIGITS;
    localparam int DIG_W      = $clog2(`TM_DIGITS);
    localparam int PAY_W      = $clog2(PAYLOAD);
    localparam int STABLE_MIN = 3 * `TM_DIGITS;  // A full scan plus the way to the snapshot

    typedef logic [PAYLOAD - 1:0][7:0] payload_t;

    logic                    prev_clk;
    logic                    prev_stb;
    logic [8 * `TM_DIGITS - 1:0] prev_ref;
    logic [`TM_DIGITS - 1:0] prev_led;
    logic                    seen_frame;
    logic                    have_last;
    logic                    last_key;   // Previous frame was a key frame
    logic                    reading;
    logic                    is_key;
    logic                    stable_ok;
    logic [7:0]              shift;
    logic [7:0]              cmd;
    logic [7:0]              exp_cmd;
    logic [7:0]              frame_bytes [0:31];
    payload_t                expected;
    int                      exp_len;
    int                      nbits;
    int                      nbytes;
    int                      stable;

    // Expected data bytes after the address command
    function automatic payload_t display_bytes(input tm1638_pkg::seg_mem_t seg,
                                               input logic [`TM_DIGITS - 1:0] led);
        payload_t b;
        for (int k = 0; k < `TM_DIGITS; k++)
        begin
            b[PAY_W'(2 * k)]     = seg[DIG_W'(k)];
            b[PAY_W'(2 * k + 1)] = {7'd0, led[DIG_W'(k)]};
        end
        return b;
    endfunction

    task automatic value_mismatch(input string name, input logic [31:0] exp,
                                  input logic [31:0] act);
        $display("[ERROR] %0d ns %s: expected %0h, got %0h", $time, name, exp, act);
        error_count++;
    endtask

    task automatic protocol_fault(input string what);
        $display("%0d ns: %s", $time, what);
        error_count++;
    endtask

    // ----------------------------------------
    // Bus decoding and comparison
    // ----------------------------------------

    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            error_count = 0;
            refreshes   = 0;
            compared    = 0;
            key_frames  = 0;
            seen_frame  = 1'b0;
            have_last   = 1'b0;
            nbits       = 0;
            nbytes      = 0;
            stable      = 0;
        end
        else
        begin
            if (seg_ref != prev_ref || ledr != prev_led)
                stable = 0;
            else if (stable < STABLE_MIN)
                stable++;

            if (!seen_frame && !(prev_stb && !sio_stb))  // Idle levels out of reset
            begin
                if (sio_stb !== 1'b1)      value_mismatch("sio_stb", 1, 32'(sio_stb));
                if (sio_clk !== 1'b1)      value_mismatch("sio_clk", 1, 32'(sio_clk));
                if (sio_data_oe !== 1'b0)  value_mismatch("sio_data_oe", 0, 32'(sio_data_oe));
                if (sio_data_out !== 1'b0) value_mismatch("sio_data_out", 0, 32'(sio_data_out));
                if (keys !== '0)           value_mismatch("keys", 0, 32'(keys));
            end

            if (prev_stb && !sio_stb)  // Frame opens
            begin
                seen_frame = 1'b1;
                nbits      = 0;
                nbytes     = 0;
                stable_ok  = (stable >= STABLE_MIN);
                expected   = display_bytes(seg_ref, ledr);
            end
            else if (!sio_stb && !prev_clk && sio_clk)  // Panel samples here
            begin
                reading = (nbytes > 0 && frame_bytes[0] == `TM_CMD_DATA_READ);
                if (sio_data_oe !== !reading)
                    value_mismatch("sio_data_oe", 32'(!reading), 32'(sio_data_oe));
                shift = {reading ? sio_data_in : sio_data_out, shift[7:1]};  // LSB first
                nbits++;
                if (nbits == 8)
                begin
                    nbits = 0;
                    if (nbytes < 32)
                        frame_bytes[5'(nbytes)] = shift;
                    nbytes++;
                end
            end
            else if (!prev_stb && sio_stb)  // Frame closes
            begin
                cmd    = frame_bytes[0];
                is_key = (cmd == `TM_CMD_DATA_READ);
                if (nbits != 0)
                    protocol_fault("strobe rose in the middle of a byte");
                if (nbytes == 0)
                    protocol_fault("strobe frame carried no byte");
                else if (is_key)
                begin
                    if (nbytes != 5)
                        value_mismatch("key frame length", 5, nbytes);
                    else if (keys !== panel_keys)
                        value_mismatch("keys", 32'(panel_keys), 32'(keys));
                    key_frames++;
                end
                else if (cmd == `TM_CMD_DATA_WRITE || cmd == `TM_CMD_ADDR
                         || cmd == `TM_CMD_DISPLAY_ON)
                begin
                    if (cmd !== exp_cmd)
                        value_mismatch("display command", 32'(exp_cmd), 32'(cmd));
                    exp_len = (cmd == `TM_CMD_ADDR) ? PAYLOAD + 1 : 1;
                    if (nbytes != exp_len)
                        value_mismatch("display frame length", exp_len, nbytes);
                    else if (cmd == `TM_CMD_ADDR && stable_ok)
                    begin
                        compared++;
                        for (int p = 0; p < PAYLOAD; p++)
                            if (frame_bytes[5'(p + 1)] !== expected[PAY_W'(p)])
                                value_mismatch($sformatf("sio_data_out display byte %0d", p),
                                               32'(expected[PAY_W'(p)]),
                                               32'(frame_bytes[5'(p + 1)]));
                    end
                    if (cmd == `TM_CMD_DISPLAY_ON)
                        refreshes++;
                    // Next frame of the refresh follows the one just seen
                    exp_cmd = (cmd == `TM_CMD_DATA_WRITE) ? `TM_CMD_ADDR :
                              (cmd == `TM_CMD_ADDR) ? `TM_CMD_DISPLAY_ON : `TM_CMD_DATA_WRITE;
                end
                else
                    protocol_fault($sformatf("unknown command byte %0h", cmd));

                if (nbytes != 0)
                begin
                    if (have_last && last_key == is_key)
                        protocol_fault(is_key ? "two key frames in a row"
                                              : "two display frames in a row");
                    have_last = 1'b1;
                    last_key  = is_key;
                end
            end
        end

        if (!rst_n)
            exp_cmd = `TM_CMD_DATA_WRITE;
        prev_clk = sio_clk;
        prev_stb = sio_stb;
        prev_ref = seg_ref;
        prev_led = ledr;
    end

endmodule

`default_nettype wire

/* hw/tm1638_board_controller.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tm1638_board_controller
(
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire  [7:0]              hgfedcba,
    input  wire  [`TM_DIGITS - 1:0] digit,
    input  wire  [`TM_DIGITS - 1:0] ledr,
    output logic [`TM_KEYS - 1:0]   keys,
    output logic                    sio_clk,
    output logic                    sio_stb,
    output logic                    sio_data_out,
    output logic                    sio_data_oe,
    input  wire                     sio_data_in
);

    // ----------------------------------------

    sio_byte_if wr_bus  ();
    sio_byte_if key_bus ();
    sio_byte_if eng_bus ();  // Arbiter to serial engine

    tm1638_display_writer i_display_writer
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    ),
        .ledr     ( ledr     ),
        .bus      ( wr_bus   )
    );

    tm1638_key_reader i_key_reader
    (
        .clk   ( clk     ),
        .rst_n ( rst_n   ),
        .keys  ( keys    ),
        .bus   ( key_bus )
    );

    sio_arbiter i_sio_arbiter
    (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .wr_bus  ( wr_bus  ),
        .key_bus ( key_bus ),
        .eng_bus ( eng_bus )
    );

    tm1638_sio_engine i_sio_engine
    (
        .clk          ( clk          ),
        .rst_n        ( rst_n        ),
        .bus          ( eng_bus      ),
        .sio_clk      ( sio_clk      ),
        .sio_stb      ( sio_stb      ),
        .sio_data_out ( sio_data_out ),
        .sio_data_oe  ( sio_data_oe  ),
        .sio_data_in  ( sio_data_in  )
    );

endmodule

`default_nettype wire

/* hw/tm1638_key_reader.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tm1638_key_reader
(
    input  wire                   clk,
    input  wire                   rst_n,
    output logic [`TM_KEYS - 1:0] keys,
    sio_byte_if.client            bus
);

    typedef enum logic [1:0] {K_REL, K_REQ, K_START, K_BUSY} state_t;

    state_t                 state;
    logic [2:0]             idx;  // 0 is the command, then key bytes
    logic                   last_byte;
    tm1638_pkg::key_bytes_t kb;
    tm1638_pkg::key_bytes_t cur;

    assign last_byte = (idx == 3'(tm1638_pkg::KEY_BYTES));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= K_REL;
            idx   <= 3'd0;
            keys  <= '0;
        end
        else
        begin
            case (state)
                K_REL:   state <= K_REQ;
                K_REQ:   if (bus.gnt) state <= K_START;
                K_START: state <= K_BUSY;
                default:
                    if (bus.done && last_byte)
                    begin
                        state <= K_REL;
                        idx   <= 3'd0;
                        // Two keys per byte, in bits 0 and 4
                        for (int i = 0; i < `TM_KEYS / 2; i++)
                        begin
                            keys[2 * i]     <= cur[i][0];
                            keys[2 * i + 1] <= cur[i][4];
                        end
                    end
                    else if (bus.done)
                    begin
                        idx   <= idx + 3'd1;
                        state <= K_START;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.done && idx != 3'd0)
            kb[2'(idx - 3'd1)] <= bus.rd_byte;
    end

    // Final byte is taken straight from the link
    always_comb
    begin
        cur = kb;
        cur[tm1638_pkg::KEY_BYTES - 1] = bus.rd_byte;
    end

    assign bus.req     = (state != K_REL);
    assign bus.start   = (state == K_START);
    assign bus.wr_byte = `TM_CMD_DATA_READ;
    assign bus.read    = (idx != 3'd0);
    assign bus.last    = last_byte;

endmodule

`default_nettype wire

/* hw/tm1638_display_writer.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tm1638_display_writer
(
    input  wire                      clk,
    input  wire                      rst_n,
    input  wire [7:0]                hgfedcba,
    input  wire [`TM_DIGITS - 1:0]   digit,
    input  wire [`TM_DIGITS - 1:0]   ledr,
    sio_byte_if.client               bus
);

    localparam int PAYLOAD = 2 * `TM_DIGITS;  // Segment and LED byte per digit
    localparam int IDX_W   = $clog2(PAYLOAD + 1);
    localparam int POS_W   = $clog2(PAYLOAD);

    typedef enum logic [1:0] {W_REL, W_REQ, W_START, W_BUSY} state_t;

    state_t                 state;
    logic [1:0]             frame;  // 0 data mode, 1 address and data, 2 display on
    logic [IDX_W - 1:0]     idx;    // Byte within the frame
    logic [POS_W - 1:0]     pos;
    logic                   last_byte;
    tm1638_pkg::seg_mem_t   seg_mem;
    tm1638_pkg::seg_mem_t   snap_mem;
    logic [`TM_DIGITS - 1:0] snap_led;

    // The lab side scans the digits, keep each pattern as it passes
    always_ff @(posedge clk)
    begin
        for (int k = 0; k < `TM_DIGITS; k++)
            if (digit[k])
                seg_mem[k] <= hgfedcba;
    end

    always_ff @(posedge clk)
    begin
        if (state == W_REQ && bus.gnt && frame == 2'd1)
        begin
            snap_mem <= seg_mem;
            snap_led <= ledr;
        end
    end

    // ----------------------------------------
    // Refresh sequence
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state <= W_REL;
            frame <= 2'd0;
            idx   <= '0;
        end
        else
        begin
            case (state)
                W_REL:   state <= W_REQ;  // Req low for a cycle frees the link
                W_REQ:   if (bus.gnt) state <= W_START;
                W_START: state <= W_BUSY;
                default:
                    if (bus.done && last_byte)
                    begin
                        state <= W_REL;
                        idx   <= '0;
                        frame <= (frame == 2'd2) ? 2'd0 : frame + 2'd1;
                    end
                    else if (bus.done)
                    begin
                        idx   <= idx + 1'b1;
                        state <= W_START;
                    end
            endcase
        end
    end

    assign pos       = POS_W'(idx - 1'b1);
    assign last_byte = (frame != 2'd1) || (idx == IDX_W'(PAYLOAD));

    always_comb
    begin
        case (frame)
            2'd0:    bus.wr_byte = `TM_CMD_DATA_WRITE;
            2'd1:
                if (idx == '0)
                    bus.wr_byte = `TM_CMD_ADDR;
                else if (pos[0])  // Odd address holds the LED
                    bus.wr_byte = {7'd0, snap_led[pos[POS_W - 1:1]]};
                else
                    bus.wr_byte = snap_mem[pos[POS_W - 1:1]];
            default: bus.wr_byte = `TM_CMD_DISPLAY_ON;
        endcase
    end

    assign bus.req   = (state != W_REL);
    assign bus.start = (state == W_START);
    assign bus.read  = 1'b0;
    assign bus.last  = last_byte;

endmodule

`default_nettype wire

/* hw/tm1638_sio_engine.sv */
`timescale 1ns/10ps
`default_nettype none

`include "tm1638_cfg.svh"

module tm1638_sio_engine
(
    input  wire         clk,
    input  wire         rst_n,
    sio_byte_if.engine  bus,
    output logic        sio_clk,
    output logic        sio_stb,
    output logic        sio_data_out,
    output logic        sio_data_oe,
    input  wire         sio_data_in
);

    localparam int HC_W = $clog2(`TM_HALF_PERIOD + 1);

    typedef enum logic [2:0]
    {
        S_IDLE, S_LEAD, S_SETUP, S_LOW, S_HIGH, S_FIN, S_GAP, S_TAIL
    } state_t;

    state_t                state;
    logic [HC_W - 1:0]     hc;       // Half period counter
    logic                  half_end;
    logic                  timed;
    logic [2:0]            bit_cnt;
    logic                  done_q;
    logic                  is_read;
    logic                  is_last;
    tm1638_pkg::sio_byte_t shreg;
    tm1638_pkg::sio_byte_t rx;

    assign half_end = (hc == HC_W'(`TM_HALF_PERIOD - 1));
    assign timed    = state inside {S_LEAD, S_SETUP, S_LOW, S_HIGH, S_TAIL};

    always_ff @(posedge clk)
    begin
        if (!rst_n || !timed || half_end)
            hc <= '0;
        else
            hc <= hc + 1'b1;
    end

    // ----------------------------------------
    // Bit sequencing
    // ----------------------------------------

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state        <= S_IDLE;
            bit_cnt      <= 3'd0;
            done_q       <= 1'b0;
            sio_clk      <= 1'b1;
            sio_stb      <= 1'b1;
            sio_data_out <= 1'b0;
            sio_data_oe  <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;

            case (state)
                S_IDLE:  if (bus.start) state <= S_LEAD;
                S_LEAD:
                    if (half_end)
                    begin
                        sio_stb <= 1'b0;
                        state   <= S_SETUP;
                    end
                S_SETUP:  // First falling edge of the byte
                    if (half_end)
                    begin
                        sio_clk      <= 1'b0;
                        sio_data_oe  <= !is_read;
                        sio_data_out <= !is_read && shreg[0];
                        bit_cnt      <= 3'd0;
                        state        <= S_LOW;
                    end
                S_LOW:
                    if (half_end)
                    begin
                        sio_clk <= 1'b1;  // Panel samples here
                        state   <= (bit_cnt == 3'd7) ? S_FIN : S_HIGH;
                    end
                S_HIGH:
                    if (half_end)
                    begin
                        sio_clk      <= 1'b0;
                        bit_cnt      <= bit_cnt + 3'd1;
                        sio_data_out <= !is_read && shreg[bit_cnt + 3'd1];
                        state        <= S_LOW;
                    end
                S_FIN:
                begin
                    done_q       <= 1'b1;
                    sio_data_oe  <= 1'b0;
                    sio_data_out <= 1'b0;
                    state        <= is_last ? S_TAIL : S_GAP;
                end
                S_GAP:   if (bus.start) state <= S_SETUP;  // Strobe stays low
                default:  // S_TAIL
                    if (half_end)
                    begin
                        sio_stb <= 1'b1;
                        state   <= S_IDLE;
                    end
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (bus.start)
        begin
            shreg   <= bus.wr_byte;
            is_read <= bus.read;
            is_last <= bus.last;
        end
        if (state == S_LOW && half_end && is_read)
            rx <= {sio_data_in, rx[7:1]};  // LSB arrives first
    end

    assign bus.gnt     = (state == S_IDLE);
    assign bus.done    = done_q;
    assign bus.rd_byte = rx;

    start_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        bus.start |-> bus.req && (state == S_IDLE || state == S_GAP));

    clk_inside_frame: assert property (@(posedge clk) disable iff (!rst_n)
        sio_stb |-> sio_clk);

endmodule

`default_nettype wire

/* hw/sio_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module sio_arbiter
(
    input  wire         clk,
    input  wire         rst_n,
    sio_byte_if.engine  wr_bus,
    sio_byte_if.engine  key_bus,
    sio_byte_if.client  eng_bus
);

    logic [1:0] owner;        // One-hot, bit 0 writer, bit 1 key reader
    logic       last_winner;  // Set when the key reader had the link last
    logic       pick_key;

    // Round robin between the two requesters
    assign pick_key = key_bus.req && (!wr_bus.req || !last_winner);

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            owner       <= 2'b00;
            last_winner <= 1'b1;  // Writer goes first
        end
        else if (owner != 2'b00)
        begin
            if (!eng_bus.req)  // Owner let go after its last byte
                owner <= 2'b00;
        end
        else if (eng_bus.gnt && (wr_bus.req || key_bus.req))
        begin
            owner       <= pick_key ? 2'b10 : 2'b01;
            last_winner <= pick_key;
        end
    end

    // ----------------------------------------
    // Byte signals follow the owner
    // ----------------------------------------

    assign wr_bus.gnt  = owner[0];
    assign key_bus.gnt = owner[1];

    assign eng_bus.req     = (owner[0] && wr_bus.req) || (owner[1] && key_bus.req);
    assign eng_bus.start   = (owner[0] && wr_bus.start) || (owner[1] && key_bus.start);
    assign eng_bus.wr_byte = owner[1] ? key_bus.wr_byte : wr_bus.wr_byte;
    assign eng_bus.read    = owner[1] ? key_bus.read    : wr_bus.read;
    assign eng_bus.last    = owner[1] ? key_bus.last    : wr_bus.last;

    assign wr_bus.done     = owner[0] && eng_bus.done;
    assign key_bus.done    = owner[1] && eng_bus.done;
    assign wr_bus.rd_byte  = owner[0] ? eng_bus.rd_byte : '0;
    assign key_bus.rd_byte = owner[1] ? eng_bus.rd_byte : '0;

    // A client starts a byte only while it holds the link
    start_needs_grant: assert property (@(posedge clk) disable iff (!rst_n)
        !(wr_bus.start && !wr_bus.gnt) && !(key_bus.start && !key_bus.gnt));

endmodule

`default_nettype wire

/* hw/sio_byte_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface sio_byte_if;

    logic                  req;      // Frame request, held for the whole frame
    logic                  gnt;      // Link granted, on the engine side: ready for a new frame
    logic                  start;    // One byte operation
    tm1638_pkg::sio_byte_t wr_byte;
    logic                  read;     // Byte is shifted in, not out
    logic                  last;     // Close the strobe frame after this byte
    logic                  done;     // Byte finished
    tm1638_pkg::sio_byte_t rd_byte;  // Valid with done

    // Side that owns the frame
    modport client
    (
        output req, start, wr_byte, read, last,
        input  gnt, done, rd_byte
    );

    // Side that serves the frame
    modport engine
    (
        input  req, start, wr_byte, read, last,
        output gnt, done, rd_byte
    );

endinterface

`default_nettype wire

/* hw/tm1638_pkg.sv */
`default_nettype none

`include "tm1638_cfg.svh"

package tm1638_pkg;

    // ----------------------------------------

    // The panel returns its key matrix in four bytes
    localparam int KEY_BYTES = 4;

    // One byte on the serial link
    typedef logic [7:0] sio_byte_t;

    // Segment patterns hgfedcba, one per digit position
    typedef sio_byte_t [`TM_DIGITS - 1:0] seg_mem_t;

    // Raw key bytes in arrival order
    typedef sio_byte_t [KEY_BYTES - 1:0] key_bytes_t;

endpackage

`default_nettype wire

/* hw/tm1638_cfg.svh */
`ifndef TM1638_CFG_SVH
`define TM1638_CFG_SVH

// ----------------------------------------
// Panel geometry
// ----------------------------------------

`define TM_DIGITS           8
`define TM_KEYS             8

// clk cycles per half period of sio_clk
`define TM_HALF_PERIOD      4

// ----------------------------------------
// TM1638 command bytes
// ----------------------------------------

`define TM_CMD_DATA_WRITE   8'h40   // Write, auto increment
`define TM_CMD_DATA_READ    8'h42   // Key scan read
`define TM_CMD_ADDR         8'hC0   // Address 0
`define TM_CMD_DISPLAY_ON   8'h8F   // Display on, full brightness

`endif
